//--- sources.f
+incdir+verification
hw/axi_bridge_pkg.sv
hw/cpu_axi_bridge.sv
hw/axi_sram_slave.sv
hw/bridge_top.sv
verification/tb_bridge_top.sv

//--- verification/tb_model.svh
// reference memory and random number generator for the bridge testbench.
// compare task, byte-lane mask and the lane-merging model write.
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [DATA_W-1:0] model_mem [MEM_WORDS]; // expected sram contents, cleared like the slave.
logic [31:0]       lcg_state;
int                error_count;

// the upper half is returned since the low bits repeat quickly.
function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
endfunction

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
        $display("ERROR at %0t: %s got 0x%h expected 0x%h", $time, name, got, want);
        error_count++;
    end
endtask

// lanes an access touches, from its size and low address bits.
function automatic logic [STRB_W-1:0] lane_mask(input xfer_size_e size, input logic [1:0] low);
    logic [STRB_W-1:0] mask;
    mask = '0;
    case (size)
        SIZE_BYTE: mask[low] = 1'b1;      // one lane.
        SIZE_HALF:
        begin
            mask[{low[1], 1'b0}] = 1'b1;  // lanes 0 and 1 or lanes 2 and 3.
            mask[{low[1], 1'b1}] = 1'b1;
        end
        default:   mask = '1;             // whole word.
    endcase
    return mask;
endfunction

// merge an accepted write into the reference word.
task automatic model_write(input logic [ADDR_W-1:0] addr, input xfer_size_e size,
                           input logic [DATA_W-1:0] wd);
    logic [STRB_W-1:0] lanes;
    lanes = lane_mask(size, addr[1:0]);
    for (int b = 0; b < STRB_W; b++)
    begin
        if (lanes[b])
            model_mem[addr[MEM_AW+1:2]][8*b +: 8] = wd[8*b +: 8]; // untouched lanes keep old bytes.
    end
endtask

`endif

//--- verification/tb_bridge_top.sv
// testbench for bridge_top with random traffic on both cpu ports.
// clock, reset, per-port stimulus, negedge checker, timeout and closing report.
`timescale 1ns/1ps
`default_nettype none

module tb_bridge_top import axi_bridge_pkg::*; ();

    localparam logic [31:0] SEED           = 32'd31366;
    localparam int          NUM_OPS        = 400;                   // per port.
    localparam int          TIMEOUT_CYCLES = NUM_OPS * 2 * 6 + 100; // both ports, generous per op.

    logic              clk;
    logic              arst_n;
    logic              req_v     [2]; // index 0 is the inst port, 1 the data port.
    logic              wr_v      [2];
    xfer_size_e        size_v    [2];
    logic [ADDR_W-1:0] addr_v    [2];
    logic [DATA_W-1:0] wdata_v   [2];
    logic [DATA_W-1:0] rdata_v   [2];
    logic              addr_ok_v [2];
    logic              data_ok_v [2];
    string             pname     [2] = '{"inst", "data"};

    logic              busy;          // a request is outstanding.
    logic              out_port;      // owner of the outstanding request.
    logic              out_wr;
    logic [DATA_W-1:0] out_exp;       // read value predicted at acceptance.
    int                acc_cnt   [2];
    int                cmp_cnt   [2];
    int                cycle_count;

    `include "tb_model.svh"

    bridge_top i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_req     (req_v[0]),
        .inst_wr      (wr_v[0]),
        .inst_size    (size_v[0]),
        .inst_addr    (addr_v[0]),
        .inst_wdata   (wdata_v[0]),
        .inst_rdata   (rdata_v[0]),
        .inst_addr_ok (addr_ok_v[0]),
        .inst_data_ok (data_ok_v[0]),
        .data_req     (req_v[1]),
        .data_wr      (wr_v[1]),
        .data_size    (size_v[1]),
        .data_addr    (addr_v[1]),
        .data_wdata   (wdata_v[1]),
        .data_rdata   (rdata_v[1]),
        .data_addr_ok (addr_ok_v[1]),
        .data_data_ok (data_ok_v[1])
    );

    always #10 clk = ~clk; // 20 ns period.

    // one random request, held until taken, then wait for its data_ok.
    task automatic issue(input int p);
        logic [15:0] r;
        r = lcg_next();
        wr_v[p]   = r[0];
        size_v[p] = (r[2:1] == 2'd0) ? SIZE_BYTE : (r[2:1] == 2'd1) ? SIZE_HALF : SIZE_WORD;
        addr_v[p] = ADDR_W'(r[9:3]); // 128-byte window so reads often hit earlier writes.
        if (size_v[p] == SIZE_HALF)
            addr_v[p][0] = 1'b0;       // aligned half-word.
        else if (size_v[p] == SIZE_WORD)
            addr_v[p][1:0] = 2'b00;    // aligned word.
        wdata_v[p] = {lcg_next(), lcg_next()};
        req_v[p]   = 1'b1;
        @(negedge clk);
        while (!addr_ok_v[p])
            @(negedge clk);
        @(posedge clk);                // acceptance edge.
        #1 req_v[p] = 1'b0;
        @(negedge clk);
        while (!data_ok_v[p])
            @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_port(input int p);
        int n;
        n = 0;
        while (n < NUM_OPS)
        begin
            if (lcg_next() % 4 != 0)   // request in three of four free cycles.
            begin
                issue(p);
                n++;
            end
            else
            begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // mid-cycle sample, the values the next rising edge acts on.
    always @(negedge clk)
    begin : sample_check
        logic was_busy;
        logic acc [2];
        if (arst_n)
        begin
            was_busy = busy;
            check_eq("data_addr_ok", addr_ok_v[1], !was_busy);
            check_eq("inst_addr_ok", addr_ok_v[0], !was_busy && !req_v[1]); // data port wins.
            acc[0] = req_v[0] && addr_ok_v[0];
            acc[1] = req_v[1] && addr_ok_v[1];
            if (acc[0] || acc[1])
            begin
                out_port = acc[1];
                check_eq("accepted_port", out_port, req_v[1]);
                check_eq("both_ports_accepted", acc[0] && acc[1], 1'b0);
                out_wr  = wr_v[out_port];
                out_exp = model_mem[addr_v[out_port][MEM_AW+1:2]];
                if (out_wr)
                    model_write(addr_v[out_port], size_v[out_port], wdata_v[out_port]);
                acc_cnt[out_port]++;
                busy = 1'b1;
            end
            if (data_ok_v[0] || data_ok_v[1])
            begin
                check_eq("data_ok_without_request", was_busy, 1'b1);
                check_eq("inst_data_ok", data_ok_v[0], !out_port);
                check_eq("data_data_ok", data_ok_v[1], out_port);
                if (!out_wr)
                    check_eq({pname[out_port], "_rdata"}, rdata_v[out_port], out_exp);
                cmp_cnt[out_port]++;
                busy = 1'b0;           // bridge idle from the next cycle.
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: traffic still running after %0d cycles, %0d errors so far",
                 cycle_count, error_count);
        $display("Errors found");
        $finish;
    end

    initial
    begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        busy        = 1'b0;
        out_port    = 1'b0;
        out_wr      = 1'b0;
        out_exp     = '0;
        lcg_state   = SEED;
        error_count = 0;
        for (int p = 0; p < 2; p++)
        begin
            req_v[p]   = 1'b0;
            wr_v[p]    = 1'b0;
            size_v[p]  = SIZE_WORD;
            addr_v[p]  = '0;
            wdata_v[p] = '0;
            acc_cnt[p] = 0;
            cmp_cnt[p] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++)
            model_mem[i] = '0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (4) @(posedge clk);     // idle cycles, addr_ok and data_ok watched by the checker.
        #1;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (2) @(posedge clk);
        for (int p = 0; p < 2; p++)
        begin
            check_eq({pname[p], "_accepts"}, acc_cnt[p], NUM_OPS);
            check_eq({pname[p], "_completions"}, cmp_cnt[p], NUM_OPS);
        end
        $display("inst %0d/%0d data %0d/%0d accepted/completed in %0d cycles, %0d errors",
                 acc_cnt[0], cmp_cnt[0], acc_cnt[1], cmp_cnt[1], cycle_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/bridge_top.sv
// bridge plus sram slave, joined by the single-beat axi channels.
`timescale 1ns/1ps
`default_nettype none

module bridge_top import axi_bridge_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              inst_req,
    input  logic              inst_wr,
    input  xfer_size_e        inst_size,
    input  logic [ADDR_W-1:0] inst_addr,
    input  logic [DATA_W-1:0] inst_wdata,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,

    input  logic              data_req,
    input  logic              data_wr,
    input  xfer_size_e        data_size,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic [DATA_W-1:0] data_rdata,
    output logic              data_addr_ok,
    output logic              data_data_ok
);

    logic [ADDR_W-1:0] araddr;  // read address channel.
    xfer_size_e        arsize;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;   // read data channel.
    logic [1:0]        rresp;
    logic              rvalid;
    logic [ADDR_W-1:0] awaddr;  // write address channel.
    xfer_size_e        awsize;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;   // write data channel.
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;   // write response channel.
    logic              bvalid;

    cpu_axi_bridge i_bridge (.*); // cpu ports and axi wires share names.

    axi_sram_slave i_sram (.*);

endmodule

`default_nettype wire

//--- hw/axi_sram_slave.sv
// single-beat axi slave in front of a word-wide sram array.
// byte-strobe writes, full-word reads, okay responses one cycle after the handshake.
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave import axi_bridge_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    input  logic [ADDR_W-1:0] araddr,
    input  xfer_size_e        arsize,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,

    input  logic [ADDR_W-1:0] awaddr,
    input  xfer_size_e        awsize,
    input  logic              awvalid,
    output logic              awready,

    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,

    output logic [1:0]        bresp,
    output logic              bvalid
);

    slave_state_e      state;
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [MEM_AW-1:0] rd_idx;
    logic [MEM_AW-1:0] wr_idx;
    logic              ar_hs;
    logic              wr_hs;

    assign rd_idx = araddr[MEM_AW+1:2]; // word index, wraps every 1 KiB.
    assign wr_idx = awaddr[MEM_AW+1:2];

    // aw and w are taken together.
    assign arready = (state == SL_IDLE);
    assign awready = (state == SL_IDLE) && awvalid && wvalid;
    assign wready  = awready;

    assign ar_hs = arvalid && arready;
    assign wr_hs = awvalid && awready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= SL_IDLE;
        end
        else
        begin
            case (state)
                SL_IDLE:
                begin
                    if (ar_hs)
                        state <= SL_RDATA;
                    else if (wr_hs)
                        state <= SL_BRESP;
                end
                SL_RDATA: state <= SL_IDLE; // rvalid lasts one cycle.
                SL_BRESP: state <= SL_IDLE; // bvalid lasts one cycle.
                default:  state <= SL_IDLE;
            endcase
        end
    end

    // array starts cleared, writes merge per lane.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (wr_hs)
        begin
            for (int b = 0; b < STRB_W; b++)
            begin
                if (wstrb[b])
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // whole word regardless of arsize.
    always_ff @(posedge clk)
    begin
        if (ar_hs)
            rdata_q <= mem[rd_idx];
    end

    assign rdata  = rdata_q;
    assign rvalid = (state == SL_RDATA);
    assign rresp  = 2'b00; // okay.
    assign bvalid = (state == SL_BRESP);
    assign bresp  = 2'b00; // okay.

    a_wr_needs_wvalid: assert property (@(posedge clk) disable iff (!arst_n)
        wr_hs |-> wvalid);

    // master's strobe lanes must agree with the size it sends.
    a_strb_matches_size: assert property (@(posedge clk) disable iff (!arst_n)
        (awvalid && wvalid) |-> ($countones(wstrb) == (1 << awsize)));

    a_arsize_legal: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid |-> arsize inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD});

endmodule

`default_nettype wire

//--- hw/cpu_axi_bridge.sv
// cpu request ports to single-beat axi master.
// data port beats instruction port, one transaction outstanding at a time.
// request register, aw/w handshake tracking, write strobe generation.
`timescale 1ns/1ps
`default_nettype none

module cpu_axi_bridge import axi_bridge_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,

    input  logic              inst_req,
    input  logic              inst_wr,
    input  xfer_size_e        inst_size,
    input  logic [ADDR_W-1:0] inst_addr,
    input  logic [DATA_W-1:0] inst_wdata,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,

    input  logic              data_req,
    input  logic              data_wr,
    input  xfer_size_e        data_size,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    output logic [DATA_W-1:0] data_rdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,

    output logic [ADDR_W-1:0] araddr,
    output xfer_size_e        arsize,
    output logic              arvalid,
    input  logic              arready,
    input  logic [DATA_W-1:0] rdata,
    input  logic [1:0]        rresp,
    input  logic              rvalid,

    output logic [ADDR_W-1:0] awaddr,
    output xfer_size_e        awsize,
    output logic              awvalid,
    input  logic              awready,

    output logic [DATA_W-1:0] wdata,
    output logic [STRB_W-1:0] wstrb,
    output logic              wvalid,
    input  logic              wready,

    input  logic [1:0]        bresp,
    input  logic              bvalid
);

    bridge_state_e     state;
    logic              own_data;   // held request came from the data port.
    logic              req_wr;
    xfer_size_e        req_size;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              aw_done;    // write address already taken.
    logic              w_done;     // write data already taken.

    logic              take_data;
    logic              take_inst;
    logic              ar_hs;
    logic              aw_hs;
    logic              w_hs;
    logic              wr_addr_end;
    logic              resp_hit;

    // data port has strict priority.
    assign data_addr_ok = (state == BR_IDLE);
    assign inst_addr_ok = (state == BR_IDLE) && !data_req;

    assign take_data = data_req && data_addr_ok;
    assign take_inst = inst_req && inst_addr_ok; // excludes take_data by construction.

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // write leaves BR_ADDR once both halves are in, in either order.
    assign wr_addr_end = (aw_done || aw_hs) && (w_done || w_hs);

    assign resp_hit = (state == BR_RESP) && (req_wr ? bvalid : rvalid);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= BR_IDLE;
            own_data <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end
        else
        begin
            case (state)
                BR_IDLE:
                begin
                    if (take_data || take_inst)
                    begin
                        state    <= BR_ADDR;
                        own_data <= take_data;
                    end
                end
                BR_ADDR:
                begin
                    if (req_wr)
                    begin
                        if (wr_addr_end)
                        begin
                            state   <= BR_RESP;
                            aw_done <= 1'b0; // flags ready for the next write.
                            w_done  <= 1'b0;
                        end
                        else
                        begin
                            aw_done <= aw_done || aw_hs;
                            w_done  <= w_done || w_hs;
                        end
                    end
                    else if (ar_hs)
                    begin
                        state <= BR_RESP;
                    end
                end
                BR_RESP:
                begin
                    if (resp_hit)
                        state <= BR_IDLE; // addr_ok back up next cycle.
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // request payload, loaded only on acceptance.
    always_ff @(posedge clk)
    begin
        if (take_data)
        begin
            req_wr    <= data_wr;
            req_size  <= data_size;
            req_addr  <= data_addr;
            req_wdata <= data_wdata;
        end
        else if (take_inst)
        begin
            req_wr    <= inst_wr;
            req_size  <= inst_size;
            req_addr  <= inst_addr;
            req_wdata <= inst_wdata;
        end
    end

    assign araddr  = req_addr;
    assign arsize  = req_size;
    assign arvalid = (state == BR_ADDR) && !req_wr;

    assign awaddr  = req_addr;
    assign awsize  = req_size;
    assign awvalid = (state == BR_ADDR) && req_wr && !aw_done;

    assign wdata   = req_wdata;
    assign wvalid  = (state == BR_ADDR) && req_wr && !w_done;

    // lanes from size and low address bits.
    always_comb
    begin
        case (req_size)
            SIZE_BYTE: wstrb = 4'b0001 << req_addr[1:0];
            SIZE_HALF: wstrb = 4'b0011 << {req_addr[1], 1'b0}; // lower or upper half.
            default:   wstrb = 4'b1111;
        endcase
    end

    // completion and read data go only to the owning port.
    assign inst_data_ok = resp_hit && !own_data;
    assign data_data_ok = resp_hit && own_data;
    assign inst_rdata   = own_data ? '0 : rdata;
    assign data_rdata   = own_data ? rdata : '0;

    a_one_addr_channel: assert property (@(posedge clk) disable iff (!arst_n)
        !(arvalid && awvalid));

    a_one_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        !(inst_data_ok && data_data_ok));

    // slave never answers with an error.
    a_resp_okay: assert property (@(posedge clk) disable iff (!arst_n)
        (rvalid |-> rresp == 2'b00) and (bvalid |-> bresp == 2'b00));

endmodule

`default_nettype wire

//--- hw/axi_bridge_pkg.sv
// shared widths and memory geometry for the cpu-to-axi bridge and its sram slave.
// transfer-size encoding plus the bridge and slave state enums.
`default_nettype none

package axi_bridge_pkg;

    localparam int ADDR_W    = 32;          // byte address width.
    localparam int DATA_W    = 32;          // data bus width.
    localparam int STRB_W    = DATA_W / 8;  // byte lanes, one strobe each.
    localparam int MEM_AW    = 8;           // word index width, taken from addr[9:2].
    localparam int MEM_WORDS = 1 << MEM_AW; // sram depth in words.

    // same encoding on the cpu side and as axsize.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } xfer_size_e;

    typedef enum logic [1:0] {
        BR_IDLE = 2'd0, // nothing held, addr_ok up.
        BR_ADDR = 2'd1, // address and/or write data handshake pending.
        BR_RESP = 2'd2  // waiting on rvalid or bvalid.
    } bridge_state_e;

    typedef enum logic [1:0] {
        SL_IDLE  = 2'd0, // arready up, aw/w accepted when both valid.
        SL_RDATA = 2'd1, // rvalid driven for one cycle.
        SL_BRESP = 2'd2  // bvalid driven for one cycle.
    } slave_state_e;

endpackage

`default_nettype wire
